/* hdl/acc_err_config.svh */
`ifndef ACC_ERR_CONFIG_SVH
`define ACC_ERR_CONFIG_SVH

// --------------------
// fixed-point format
// --------------------
`define ACC_DATA_W   32  // Q16.16 word
`define ACC_FRAC_W   16  // fraction bits

`define ACC_NUM_PROD 6   // products per cross product

`endif

/* hdl/acc_err_ctrl.sv */
`timescale 1ns/1ps
`include "acc_err_config.svh"

module acc_err_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  logic                    out_ready,
  input  logic                    vec_done,
  output logic                    in_ready,
  output logic                    out_valid,
  output logic                    capture,
  output logic                    issue,
  output logic                    last,
  output acc_err_pkg::prod_idx_t  issue_idx
);

  acc_err_pkg::ctrl_state_e  state_q;
  acc_err_pkg::ctrl_state_e  state_d;
  acc_err_pkg::prod_idx_t    cnt_q;
  logic                      cnt_last;

  // --------------------
  // handshake decode
  // --------------------
  assign in_ready  = (state_q == acc_err_pkg::st_idle);
  assign out_valid = (state_q == acc_err_pkg::st_hold);
  assign capture   = in_valid && in_ready;
  assign issue     = (state_q == acc_err_pkg::st_issue);
  assign issue_idx = cnt_q;

  assign cnt_last = (cnt_q == acc_err_pkg::prod_idx_t'(`ACC_NUM_PROD - 1));
  assign last     = issue && cnt_last;  // final product of the set

  always_comb begin
    state_d = state_q;
    case (state_q)
      acc_err_pkg::st_idle: begin
        if (capture) state_d = acc_err_pkg::st_issue;
      end
      acc_err_pkg::st_issue: begin
        if (cnt_last) state_d = acc_err_pkg::st_drain;
      end
      acc_err_pkg::st_drain: begin
        if (vec_done) state_d = acc_err_pkg::st_hold;  // error vector ready
      end
      acc_err_pkg::st_hold: begin
        if (out_ready) state_d = acc_err_pkg::st_idle;
      end
      default: state_d = acc_err_pkg::st_idle;
    endcase
  end

  // --------------------
  // state and counter
  // --------------------
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q <= acc_err_pkg::st_idle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (issue) begin
        if (cnt_last) cnt_q <= '0;
        else          cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

/* hdl/acc_err_pkg.sv */
`include "acc_err_config.svh"

package acc_err_pkg;

  // --------------------
  // scalar types
  // --------------------
  typedef logic signed [`ACC_DATA_W-1:0]   fix_t;      // Q16.16
  typedef logic signed [2*`ACC_DATA_W-1:0] prod_t;     // full product, Q32.32
  typedef logic [$clog2(`ACC_NUM_PROD)-1:0] prod_idx_t;

  // --------------------
  // bundles
  // --------------------
  typedef struct packed {
    fix_t x;
    fix_t y;
    fix_t z;
  } vec3_t;

  typedef struct packed {
    vec3_t acc;      // accelerometer reading
    vec3_t dcm_col;  // c13, c23, c33
  } acc_in_t;

  typedef struct packed {
    fix_t      a;
    fix_t      b;
    prod_idx_t idx;
    logic      last;
    logic      valid;
  } mult_req_t;

  typedef struct packed {
    fix_t      p;     // scaled back to Q16.16
    prod_idx_t idx;
    logic      last;
    logic      valid;
  } mult_rsp_t;

  typedef enum logic [1:0] {
    st_idle,   // waiting for input
    st_issue,  // feeding the multiplier
    st_drain,  // products still in flight
    st_hold    // result offered
  } ctrl_state_e;

endpackage

/* hdl/acc_err_top.sv */
`timescale 1ns/1ps

module acc_err_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  acc_err_pkg::acc_in_t  in_data,
  output logic                  out_valid,
  input  logic                  out_ready,
  output acc_err_pkg::vec3_t    out_data
);

  logic                    capture;
  logic                    issue;
  logic                    last;
  logic                    vec_done;
  acc_err_pkg::prod_idx_t  issue_idx;
  acc_err_pkg::mult_req_t  req;
  acc_err_pkg::mult_rsp_t  rsp;

  acc_err_ctrl i_ctrl (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_ready (out_ready),
    .vec_done  (vec_done),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .capture   (capture),
    .issue     (issue),
    .last      (last),
    .issue_idx (issue_idx)
  );

  operand_bank i_bank (
    .clk       (clk),
    .rst       (rst),
    .capture   (capture),
    .issue     (issue),
    .last      (last),
    .in_data   (in_data),
    .issue_idx (issue_idx),
    .req       (req)
  );

  fix_mult_pipe i_mult (
    .clk (clk),
    .rst (rst),
    .req (req),
    .rsp (rsp)
  );

  cross_combine i_comb (
    .clk      (clk),
    .rst      (rst),
    .rsp      (rsp),
    .vec_done (vec_done),
    .err_vec  (out_data)
  );

endmodule

/* hdl/cross_combine.sv */
`timescale 1ns/1ps

module cross_combine (
  input  logic                    clk,
  input  logic                    rst,
  input  acc_err_pkg::mult_rsp_t  rsp,
  output logic                    vec_done,
  output acc_err_pkg::vec3_t      err_vec
);

  acc_err_pkg::fix_t  pend_q;  // minuend waiting for its partner
  acc_err_pkg::fix_t  diff;
  acc_err_pkg::vec3_t err_q;
  logic               is_minuend;
  logic               is_subtr;

  assign is_minuend = rsp.valid && !rsp.idx[0];  // even index
  assign is_subtr   = rsp.valid &&  rsp.idx[0];  // odd index
  assign diff       = pend_q - rsp.p;             // 32-bit wrap

  always_ff @(posedge clk) begin
    if (is_minuend) pend_q <= rsp.p;
  end

  // --------------------
  // error vector
  // --------------------
  always_ff @(posedge clk) begin
    if (is_subtr) begin
      case (rsp.idx[2:1])
        2'd0:    err_q.x <= diff;  // exa
        2'd1:    err_q.y <= diff;  // eya
        default: err_q.z <= diff;  // eza
      endcase
    end
  end

  // last tag rides with the final subtrahend
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      vec_done <= 1'b0;
    end else begin
      vec_done <= rsp.valid && rsp.last;
    end
  end

  assign err_vec = err_q;  // held until next transaction overwrites

endmodule

/* hdl/fix_mult_pipe.sv */
`timescale 1ns/1ps
`include "acc_err_config.svh"

module fix_mult_pipe (
  input  logic                    clk,
  input  logic                    rst,
  input  acc_err_pkg::mult_req_t  req,
  output acc_err_pkg::mult_rsp_t  rsp
);

  acc_err_pkg::prod_t      full;
  acc_err_pkg::prod_t      prod_q;    // stage one
  acc_err_pkg::prod_idx_t  idx1_q;
  logic                    last1_q;
  logic                    valid1_q;
  acc_err_pkg::fix_t       p_q;       // stage two
  acc_err_pkg::prod_idx_t  idx2_q;
  logic                    last2_q;
  logic                    valid2_q;

  assign full = req.a * req.b;  // both signed, so sign-extended to 64

  // --------------------
  // data stages
  // --------------------
  always_ff @(posedge clk) begin
    prod_q  <= full;
    idx1_q  <= req.idx;
    last1_q <= req.last;
    p_q     <= prod_q[`ACC_DATA_W+`ACC_FRAC_W-1:`ACC_FRAC_W];  // floor, wraps
    idx2_q  <= idx1_q;
    last2_q <= last1_q;
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      valid1_q <= 1'b0;
      valid2_q <= 1'b0;
    end else begin
      valid1_q <= req.valid;
      valid2_q <= valid1_q;
    end
  end

  assign rsp = '{p: p_q, idx: idx2_q, last: last2_q, valid: valid2_q};

endmodule

/* hdl/operand_bank.sv */
`timescale 1ns/1ps

module operand_bank (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    capture,
  input  logic                    issue,
  input  logic                    last,
  input  acc_err_pkg::acc_in_t    in_data,
  input  acc_err_pkg::prod_idx_t  issue_idx,
  output acc_err_pkg::mult_req_t  req
);

  acc_err_pkg::vec3_t      acc_q;
  acc_err_pkg::vec3_t      dcm_q;
  acc_err_pkg::fix_t       sel_a;
  acc_err_pkg::fix_t       sel_b;
  acc_err_pkg::fix_t       a_q;
  acc_err_pkg::fix_t       b_q;
  acc_err_pkg::prod_idx_t  idx_q;
  logic                    last_q;
  logic                    valid_q;

  always_ff @(posedge clk) begin
    if (capture) begin
      acc_q <= in_data.acc;
      dcm_q <= in_data.dcm_col;
    end
  end

  // --------------------
  // operand table
  // --------------------
  always_comb begin
    case (issue_idx)
      3'd0:    {sel_a, sel_b} = {acc_q.y, dcm_q.z};  // ay*c33
      3'd1:    {sel_a, sel_b} = {acc_q.z, dcm_q.y};  // az*c23
      3'd2:    {sel_a, sel_b} = {acc_q.z, dcm_q.x};  // az*c13
      3'd3:    {sel_a, sel_b} = {acc_q.x, dcm_q.z};  // ax*c33
      3'd4:    {sel_a, sel_b} = {acc_q.x, dcm_q.y};  // ax*c23
      default: {sel_a, sel_b} = {acc_q.y, dcm_q.x};  // ay*c13
    endcase
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      a_q    <= sel_a;
      b_q    <= sel_b;
      idx_q  <= issue_idx;
      last_q <= last;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) valid_q <= 1'b0;
    else      valid_q <= issue;
  end

  assign req = '{a: a_q, b: b_q, idx: idx_q, last: last_q, valid: valid_q};

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module acc_err_tb -f src.f -o acc_err_sim \
  && ./obj_dir/acc_err_sim | tee /dev/stderr | grep -q "TB PASSED" \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }

/* src.f */
+incdir+hdl
hdl/acc_err_pkg.sv
hdl/operand_bank.sv
hdl/fix_mult_pipe.sv
hdl/cross_combine.sv
hdl/acc_err_ctrl.sv
hdl/acc_err_top.sv
verification/acc_err_assertions.sv
verification/acc_err_tb.sv

/* verification/acc_err_assertions.sv */
`timescale 1ns/1ps

module acc_err_assertions (
  input logic                clk,
  input logic                rst,
  input logic                in_ready,
  input logic                out_valid,
  input logic                out_ready,
  input acc_err_pkg::vec3_t  out_data
);

  int fail_cnt = 0;  // failed assertion count

  // --------------------
  // output handshake
  // --------------------
  property out_held;
    @(posedge clk) disable iff (!rst)
      out_valid && !out_ready |=> out_valid && $stable(out_data);
  endproperty

  property back_to_idle;
    @(posedge clk) disable iff (!rst)
      out_valid && out_ready |=> in_ready && !out_valid;
  endproperty

  // only one side is open at a time
  property one_side_open;
    @(posedge clk) disable iff (!rst)
      !(in_ready && out_valid);
  endproperty

  a_out_held: assert property (out_held)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("out_data or out_valid changed while stalled");
    end
  a_back_to_idle: assert property (back_to_idle)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("in_ready not raised after output transfer");
    end
  a_one_side_open: assert property (one_side_open)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("in_ready and out_valid high together");
    end

endmodule

bind acc_err_top acc_err_assertions i_assert (
  .clk       (clk),
  .rst       (rst),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data)
);

/* verification/acc_err_tb.sv */
`timescale 1ns/1ps
`include "acc_err_config.svh"

module acc_err_tb;

  localparam int num_rows   = 10;
  localparam int wait_limit = 30;  // cycles per wait

  logic                  clk;
  logic                  rst;
  logic                  in_valid;
  logic                  in_ready;
  acc_err_pkg::acc_in_t  in_data;
  logic                  out_valid;
  logic                  out_ready;
  acc_err_pkg::vec3_t    out_data;

  acc_err_pkg::acc_in_t  stim [num_rows];
  acc_err_pkg::vec3_t    expv [num_rows];  // expected error vectors
  int                    accepted = 0;     // input transfers seen at the DUT

  acc_err_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns period

  always @(posedge clk) begin
    if (in_valid && in_ready) accepted <= accepted + 1;
  end

  // --------------------
  // reference model
  // --------------------
  function automatic acc_err_pkg::fix_t qmul(input acc_err_pkg::fix_t a,
                                             input acc_err_pkg::fix_t b);
    longint full;
    full = longint'(a) * longint'(b);
    return acc_err_pkg::fix_t'(full >>> `ACC_FRAC_W);  // floor, keep low 32 bits
  endfunction

  function automatic acc_err_pkg::vec3_t cross_ref(input acc_err_pkg::vec3_t a,
                                                   input acc_err_pkg::vec3_t c);
    acc_err_pkg::vec3_t r;
    r.x = qmul(a.y, c.z) - qmul(a.z, c.y);  // exa
    r.y = qmul(a.z, c.x) - qmul(a.x, c.z);  // eya
    r.z = qmul(a.x, c.y) - qmul(a.y, c.x);  // eza
    return r;
  endfunction

  function automatic acc_err_pkg::fix_t to_fix(input real v);
    return acc_err_pkg::fix_t'($rtoi(v * (2.0 ** `ACC_FRAC_W)));
  endfunction

  task automatic set_row(input int i, input real ax, input real ay, input real az,
                         input real c13, input real c23, input real c33);
    stim[i].acc     = '{x: to_fix(ax), y: to_fix(ay), z: to_fix(az)};
    stim[i].dcm_col = '{x: to_fix(c13), y: to_fix(c23), z: to_fix(c33)};
  endtask

  // --------------------
  // checks and waits
  // --------------------
  task automatic check(input logic [95:0] got, input logic [95:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timed out after %0d cycles waiting for %s", wait_limit, what);
    $display("TB FAILED");
    $fatal(1, "timeout");
  endtask

  task automatic wait_in_ready();
    int n;
    n = 0;
    while (!in_ready) begin
      if (n == wait_limit) fail_timeout("in_ready");
      @(negedge clk);
      n++;
    end
  endtask

  task automatic wait_out_valid();
    int n;
    n = 0;
    while (!out_valid) begin
      if (n == wait_limit) fail_timeout("out_valid");
      check(96'(in_ready), 96'd0, "in_ready while busy");
      @(negedge clk);
      n++;
    end
  endtask

  // one row with out_ready held low for a while
  task automatic run_stalled(input int i);
    acc_err_pkg::vec3_t held;
    int                 stall;
    in_data  = stim[i];
    in_valid = 1'b1;
    wait_in_ready();
    @(negedge clk);
    in_valid = 1'b0;
    in_data  = ~stim[i];  // operands must stay captured
    wait_out_valid();
    held  = out_data;
    stall = $urandom_range(10, 1);
    for (int k = 0; k < stall; k++) begin
      check(96'(out_valid), 96'd1, "out_valid under stall");
      check(96'(in_ready), 96'd0, "in_ready under stall");
      check(out_data, held, "out_data under stall");
      @(negedge clk);
    end
    check(out_data, expv[i], $sformatf("row %0d stalled result", i));
    out_ready = 1'b1;
    @(negedge clk);
    out_ready = 1'b0;
    check(96'(out_valid), 96'd0, "out_valid after transfer");
    check(96'(in_ready), 96'd1, "in_ready after transfer");
  endtask

  // in_valid and out_ready stay high across all rows
  task automatic run_back_to_back();
    int first;
    out_ready = 1'b1;
    in_valid  = 1'b1;
    in_data   = stim[0];
    first     = accepted;
    for (int i = 0; i < num_rows; i++) begin
      wait_in_ready();
      @(negedge clk);
      if (i + 1 < num_rows) begin
        in_data = stim[i + 1];
      end else begin
        in_valid = 1'b0;
      end
      wait_out_valid();
      check(out_data, expv[i], $sformatf("row %0d back-to-back result", i));
      @(negedge clk);
    end
    out_ready = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check(96'(out_valid), 96'd0, "out_valid after last row");
      check(96'(in_ready), 96'd1, "in_ready after last row");
    end
    check(96'(accepted - first), 96'(num_rows), "accepted row count");
  endtask

  initial begin
    int i;
    void'($urandom(32'hb776));
    rst       = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;

    set_row(0, 1.0, 2.0, 3.0, 0.5, -0.25, 0.75);
    set_row(1, -1.5, 0.125, -9.75, -0.375, 0.625, -2.0);
    set_row(2, 2.0, 4.0, 6.0, 1.0, 2.0, 3.0);         // parallel, zero error
    set_row(3, 0.0, 32767.0, -32768.0, 0.0, 1.0, 1.0); // exa difference wraps
    set_row(4, 100.5, -200.25, 12.0625, 0.001953125, -0.5, 0.99609375);
    for (i = 5; i < num_rows; i++) begin
      stim[i] = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
    end
    for (i = 0; i < num_rows; i++) begin
      expv[i] = cross_ref(stim[i].acc, stim[i].dcm_col);
    end

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    @(negedge clk);
    check(96'(in_ready), 96'd1, "in_ready after reset");
    check(96'(out_valid), 96'd0, "out_valid after reset");

    for (i = 0; i < num_rows; i++) begin
      run_stalled(i);
    end
    run_back_to_back();

    if (i_dut.i_assert.fail_cnt == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("%0d handshake assertions failed", i_dut.i_assert.fail_cnt);
      $display("TB FAILED");
      $fatal(1, "assertion failure");
    end
  end

endmodule
